//--- logic/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // fetch addresses
    localparam logic [31:0] RESET_PC = 32'h0000_002C;  // first fetch after reset
    localparam logic [31:0] ISR_PC   = 32'h0000_0000;  // interrupt handler entry

    // instruction queue geometry
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);  // holds 0..depth

    // funct3 codes of the kept instructions
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_BYTE = 3'b000;  // lb / sb

    // mret is matched on the full word
    localparam logic [ILEN-1:0] MRET_INSN = 32'h3020_0073;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // execute sequencing
    typedef enum logic [1:0] {
        EX_RUN,       // one instruction per handshake
        EX_BUS_REQ,   // request out, waiting for accept
        EX_BUS_WAIT   // load accepted, waiting for data
    } exec_state_e;

    // one queue entry
    typedef struct packed {
        logic [31:0]     pc;
        logic [ILEN-1:0] instr;
    } fetch_item_t;

    // data bus request
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;  // byte in [7:0], rest zero
        logic            write;
    } bus_req_t;

    // execute to fetch and queue
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      reset,
    output logic [31:0]               imem_addr,
    input  logic [core_pkg::ILEN-1:0] imem_data,
    output logic                      fetch_valid,
    output core_pkg::fetch_item_t     fetch_item,
    input  logic                      fetch_ready,
    input  core_pkg::redirect_t       redirect
);
    import core_pkg::*;

    logic [31:0] pc;
    logic        push;  // item accepted by the queue

    // memory answers in the same cycle
    assign imem_addr = pc;

    assign fetch_item.pc    = pc;
    assign fetch_item.instr = imem_data;

    // no push on a redirect cycle, the queue flushes anyway
    assign fetch_valid = reset && !redirect.valid;  // first push on the first edge after release
    assign push        = fetch_valid && fetch_ready;

    // pc: redirect first, else step on accept
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;  // resume at target next cycle
        end else if (push) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

//--- logic/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push_valid,
    input  core_pkg::fetch_item_t push_item,
    output logic                  push_ready,
    output logic                  pop_valid,
    output core_pkg::fetch_item_t pop_item,
    input  logic                  pop_ready,
    input  logic                  flush
);
    import core_pkg::*;

    fetch_item_t            mem [QUEUE_DEPTH];  // entry storage
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign push_ready = (count != QUEUE_CNT_W'(QUEUE_DEPTH));  // not full
    assign pop_valid  = (count != '0);
    assign pop_item   = mem[rd_ptr];

    // flush wins over both sides
    assign do_push = push_valid && push_ready && !flush;
    assign do_pop  = pop_valid && pop_ready && !flush;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // drop wrong-path entries
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or pass-through
            endcase
        end
    end

    // never pushed when full so the count stays in range and a full queue has met pointers
    a_no_push_full: assert property (@(posedge clk) disable iff (!reset)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH)
        && (count != QUEUE_CNT_W'(QUEUE_DEPTH) || wr_ptr == rd_ptr));

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  core_pkg::fetch_item_t     inst_item,
    output logic                      inst_ready,
    output core_pkg::redirect_t       redirect,
    output logic                      bus_req_valid,
    output core_pkg::bus_req_t        bus_req,
    input  logic                      bus_req_ready,
    input  logic                      bus_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] bus_rsp_data,
    input  logic                      irq,
    output logic                      irq_ack
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [32];  // x0 slot never written
    exec_state_e     state;
    opcode_e         op;
    logic [ILEN-1:0] instr;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic            take_irq;
    logic            fire;      // instruction popped and executed
    logic            is_load;
    logic            is_store;
    logic            is_mret;
    logic            mem_op;
    logic            irq_en;
    logic [31:0]     mepc;      // return pc
    logic [4:0]      load_rd;
    bus_req_t        req_q;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [XLEN-1:0] wr_data;

    // field split
    assign instr  = inst_item.instr;
    assign op     = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // immediates, all sign-extended to xlen
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // irq only at a boundary with an instruction waiting
    assign take_irq   = (state == EX_RUN) && irq_en && irq && inst_valid;
    assign inst_ready = (state == EX_RUN) && inst_valid && !take_irq;
    assign fire       = inst_ready;  // ready already implies valid

    assign is_load  = (op == OP_LOAD) && (funct3 == F3_BYTE);
    assign is_store = (op == OP_STORE) && (funct3 == F3_BYTE);
    assign is_mret  = fire && (op == OP_SYSTEM) && (instr == MRET_INSN);
    assign mem_op   = fire && (is_load || is_store);

    assign irq_ack         = take_irq;
    assign redirect.valid  = take_irq || is_mret;
    assign redirect.target = take_irq ? ISR_PC : mepc;

    assign bus_req_valid = (state == EX_BUS_REQ);
    assign bus_req       = req_q;

    // single register write port
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = rd;
        wr_data = '0;
        if (state == EX_BUS_WAIT) begin
            wr_en   = bus_rsp_valid;  // lb result
            wr_addr = load_rd;
            wr_data = {{(XLEN-8){bus_rsp_data[7]}}, bus_rsp_data[7:0]};
        end else if (fire) begin
            case (op)
                OP_LUI: begin
                    wr_en   = 1'b1;
                    wr_data = imm_u;
                end
                OP_IMM: begin
                    wr_en   = (funct3 == F3_ADDI);  // other alu ops retire as no-op
                    wr_data = rs1_val + imm_i;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // latch the bus request on pop
    always_ff @(posedge clk) begin
        if (mem_op) begin
            req_q.addr  <= rs1_val + (is_store ? imm_s : imm_i);
            req_q.wdata <= {{(XLEN-8){1'b0}}, rs2_val[7:0]};
            req_q.write <= is_store;
            load_rd     <= rd;
        end
    end

    // interrupt state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            irq_en <= 1'b1;
            mepc   <= RESET_PC;
        end else if (take_irq) begin
            irq_en <= 1'b0;
            mepc   <= inst_item.pc;  // head is replayed after mret
        end else if (is_mret) begin
            irq_en <= 1'b1;
        end
    end

    // bus sequencing
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= EX_RUN;
        end else begin
            case (state)
                EX_RUN: begin
                    if (mem_op) begin
                        state <= EX_BUS_REQ;  // request goes out next cycle
                    end
                end
                EX_BUS_REQ: begin
                    if (bus_req_ready) begin
                        state <= req_q.write ? EX_RUN : EX_BUS_WAIT;  // sb done on accept
                    end
                end
                EX_BUS_WAIT: begin
                    if (bus_rsp_valid) begin
                        state <= EX_RUN;
                    end
                end
                default: state <= EX_RUN;
            endcase
        end
    end

    // request held until the slave takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!reset)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req));

    // single-cycle redirects and acks only between bus accesses
    a_redir_run: assert property (@(posedge clk) disable iff (!reset)
        (redirect.valid || irq_ack) |-> (state == EX_RUN) ##1 (!redirect.valid && !irq_ack));

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                      clk,
    input  logic                      reset,
    output logic [31:0]               imem_addr,
    input  logic [core_pkg::ILEN-1:0] imem_data,
    output logic                      bus_req_valid,
    output core_pkg::bus_req_t        bus_req,
    input  logic                      bus_req_ready,
    input  logic                      bus_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] bus_rsp_data,
    input  logic                      irq,
    output logic                      irq_ack
);
    import core_pkg::*;

    logic        fetch_valid;   // fetch -> queue
    logic        fetch_ready;
    fetch_item_t fetch_item;
    logic        inst_valid;    // queue -> execute
    logic        inst_ready;
    fetch_item_t inst_item;
    redirect_t   redirect;      // to fetch pc and queue flush

    fetch_unit i_fetch (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_valid (fetch_valid),
        .fetch_item  (fetch_item),
        .fetch_ready (fetch_ready),
        .redirect    (redirect)
    );

    fetch_queue i_queue (
        .clk        (clk),
        .reset      (reset),
        .push_valid (fetch_valid),
        .push_item  (fetch_item),
        .push_ready (fetch_ready),
        .pop_valid  (inst_valid),
        .pop_item   (inst_item),
        .pop_ready  (inst_ready),
        .flush      (redirect.valid)  // wrong-path entries dropped
    );

    exec_unit i_exec (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst_item     (inst_item),
        .inst_ready    (inst_ready),
        .redirect      (redirect),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_req_ready (bus_req_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_data  (bus_rsp_data),
        .irq           (irq),
        .irq_ack       (irq_ack)
    );

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    typedef struct packed {
        logic [19:0] lui_imm;   // x1 upper immediate
        logic [11:0] imm_a;     // x2 = x1 + imm_a
        logic [11:0] imm_b;     // x5 = x3 + imm_b
        logic [7:0]  load_val;  // byte the slave returns for lb
        logic        irq_on;
        logic [63:0] rd_addr;   // expected lb address, x1 + 8
        logic [7:0]  byte_x2;   // expected low byte of x2
        logic [7:0]  byte_x5;   // expected low byte of x5
    } case_t;

    logic            clk = 1'b0;
    logic            reset;
    logic [31:0]     imem_addr;
    logic [ILEN-1:0] imem_data;
    logic            bus_req_valid;
    bus_req_t        bus_req;
    logic            bus_req_ready = 1'b0;
    logic            bus_rsp_valid = 1'b0;
    logic [XLEN-1:0] bus_rsp_data  = '0;
    logic            irq;
    logic            irq_ack;

    logic [31:0] prog [256];     // 1 KB instruction memory
    case_t       cases [5];
    logic [63:0] wr_addr_q [$];  // bus writes, in order
    logic [63:0] wr_data_q [$];
    logic [63:0] rd_addr_q [$];
    int          ack_cnt    = 0;
    int          rsp_wait   = 0;  // cycles left to read data
    logic [31:0] rng        = 32'd56;
    logic [7:0]  cur_load   = '0;
    int          check_errs = 0;
    int          timeout_errs = 0;

    core_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_req_ready (bus_req_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_data  (bus_rsp_data),
        .irq           (irq),
        .irq_ack       (irq_ack)
    );

    always #2 clk = ~clk;  // 4 ns period

    // same-cycle answer, zero past 1 KB
    assign imem_data = (imem_addr[31:10] == '0) ? prog[imem_addr[9:2]] : '0;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // i-type, funct3 zero (addi / lb)
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_sb(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
    endfunction

    task automatic load_program(input case_t cs);
        int b;
        b = int'(RESET_PC[9:2]);
        for (int i = 0; i < 256; i++) begin
            prog[i] = enc_i(12'(i * 4), 5'd0, 5'd0, 7'b0010011);  // addi x0, x0, addr
        end
        prog[0]      = enc_sb(12'h100, 5'd31, 5'd0);              // handler marker store
        prog[1]      = 32'h3020_0073;                             // mret
        prog[b]      = enc_i(12'h05A, 5'd0, 5'd31, 7'b0010011);   // x31 = marker byte
        prog[b + 1]  = {cs.lui_imm, 5'd1, 7'b0110111};            // lui x1
        prog[b + 2]  = enc_i(cs.imm_a, 5'd1, 5'd2, 7'b0010011);   // addi x2, x1
        prog[b + 3]  = enc_sb(12'h010, 5'd2, 5'd2);               // sb x2, 16(x2)
        prog[b + 4]  = enc_i(12'h008, 5'd1, 5'd3, 7'b0000011);    // lb x3, 8(x1)
        prog[b + 5]  = enc_i(cs.imm_b, 5'd3, 5'd5, 7'b0010011);   // addi x5, x3
        prog[b + 6]  = enc_sb(12'h020, 5'd5, 5'd0);
        prog[b + 7]  = enc_i(12'h077, 5'd0, 5'd0, 7'b0010011);    // write to x0, dropped
        prog[b + 8]  = enc_sb(12'h021, 5'd0, 5'd0);               // x0 still zero
        prog[b + 9]  = enc_sb(12'h022, 5'd2, 5'd0);               // store burst
        prog[b + 10] = enc_sb(12'h023, 5'd5, 5'd0);
        prog[b + 11] = enc_sb(12'h024, 5'd3, 5'd0);
    endtask

    // bus slave: log at the edge, drive 1 ns later
    always @(posedge clk) begin
        if (!reset) begin
            wr_addr_q.delete();
            wr_data_q.delete();
            rd_addr_q.delete();
            ack_cnt  = 0;
            rsp_wait = 0;
        end else begin
            if (bus_req_valid && bus_req_ready) begin
                if (bus_req.write) begin
                    wr_addr_q.push_back(bus_req.addr);
                    wr_data_q.push_back(bus_req.wdata);
                end else begin
                    rd_addr_q.push_back(bus_req.addr);
                    rng      = xorshift32(rng);
                    rsp_wait = 1 + int'(rng % 32'd3);  // 1 to 3 cycles
                end
            end
            if (irq_ack) begin
                ack_cnt++;
            end
        end
        #1;
        rng           = xorshift32(rng);
        bus_req_ready = (rng[1:0] != 2'b00);  // low about a quarter of cycles
        bus_rsp_valid = 1'b0;
        if (rsp_wait > 0) begin
            rsp_wait--;
            if (rsp_wait == 0) begin
                bus_rsp_valid = 1'b1;
                bus_rsp_data  = {56'h0123_4567_89AB_CD, cur_load};  // junk above the byte
            end
        end
    end

    task automatic run_case(input int idx);
        case_t       cs;
        logic [63:0] x1;
        logic [63:0] exp_addr [6];
        logic [7:0]  exp_byte [6];
        int          n_exp;
        int          irq_at;
        int          t;
        int          k;
        int          marks;
        logic        irq_done;
        cs = cases[idx];
        @(posedge clk);
        #1;
        reset    = 1'b0;
        irq      = 1'b0;
        cur_load = cs.load_val;
        load_program(cs);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;

        // lui sign-extends, sb address is x2 + 16
        x1       = {{32{cs.lui_imm[19]}}, cs.lui_imm, 12'h000};
        exp_addr = '{x1 + {{52{cs.imm_a[11]}}, cs.imm_a} + 64'h10,
                     64'h20, 64'h21, 64'h22, 64'h23, 64'h24};
        exp_byte = '{cs.byte_x2, cs.byte_x5, 8'h00, cs.byte_x2, cs.byte_x5, cs.load_val};
        n_exp    = 6 + int'(cs.irq_on);
        irq_at   = (idx % 2 == 0) ? 4 : 2;  // stores seen before irq goes up
        irq_done = 1'b0;

        for (t = 0; t < 600 && wr_addr_q.size() < n_exp; t++) begin
            @(posedge clk);
            #1;
            if (cs.irq_on && !irq_done && !irq && wr_addr_q.size() >= irq_at) begin
                irq = 1'b1;
            end else if (irq && ack_cnt > 0) begin
                irq      = 1'b0;  // one raise, one ack
                irq_done = 1'b1;
            end
        end
        irq = 1'b0;
        if (wr_addr_q.size() < n_exp) begin
            $display("case %0d stalled: %0d of %0d bus writes after 600 cycles",
                     idx, wr_addr_q.size(), n_exp);
            timeout_errs++;
        end
        for (t = 0; t < 20; t++) begin
            @(posedge clk);  // room for stray extra writes
        end
        #1;

        // marker writes pulled out, the rest must match program order
        marks = 0;
        k     = 0;
        for (int i = 0; i < wr_addr_q.size(); i++) begin
            if (wr_addr_q[i] == 64'h100) begin
                marks++;
                if (wr_data_q[i] != 64'h5A) begin
                    $display("FAIL case %0d bus_req.wdata: got %h expected %h",
                             idx, wr_data_q[i], 64'h5A);
                    check_errs++;
                end
            end else begin
                if (k < 6 && wr_addr_q[i] != exp_addr[k]) begin
                    $display("FAIL case %0d bus_req.addr: got %h expected %h",
                             idx, wr_addr_q[i], exp_addr[k]);
                    check_errs++;
                end
                if (k < 6 && wr_data_q[i] != {56'h0, exp_byte[k]}) begin
                    $display("FAIL case %0d bus_req.wdata: got %h expected %h",
                             idx, wr_data_q[i], {56'h0, exp_byte[k]});
                    check_errs++;
                end
                k++;
            end
        end
        if (k != 6) begin
            $display("case %0d: %0d program stores seen, expected 6", idx, k);
            check_errs++;
        end
        if (marks != int'(cs.irq_on)) begin
            $display("case %0d: %0d handler marker writes, expected %0d", idx, marks, cs.irq_on);
            check_errs++;
        end
        if (ack_cnt != int'(cs.irq_on)) begin
            $display("case %0d: irq_ack pulsed %0d times, expected %0d", idx, ack_cnt, cs.irq_on);
            check_errs++;
        end
        if (rd_addr_q.size() != 1) begin
            $display("case %0d: %0d bus reads, expected 1", idx, rd_addr_q.size());
            check_errs++;
        end else if (rd_addr_q[0] != cs.rd_addr) begin
            $display("FAIL case %0d bus_req.addr: got %h expected %h",
                     idx, rd_addr_q[0], cs.rd_addr);
            check_errs++;
        end
    endtask

    initial begin
        reset = 1'b0;
        irq   = 1'b0;
        //         lui        imm_a    imm_b    load   irq   lb address                 x2     x5
        cases[0] = '{20'h00012, 12'h005, 12'h003, 8'h85, 1'b0, 64'h12008, 8'h05, 8'h88};
        cases[1] = '{20'h00034, 12'hFF0, 12'hFFE, 8'hC3, 1'b0, 64'h34008, 8'hF0, 8'hC1};
        cases[2] = '{20'h80001, 12'h7FF, 12'h005, 8'h7E, 1'b0, 64'hFFFF_FFFF_8000_1008,
                     8'hFF, 8'h83};
        cases[3] = '{20'h00056, 12'h021, 12'h010, 8'hF0, 1'b1, 64'h56008, 8'h21, 8'h00};
        cases[4] = '{20'h00078, 12'hF80, 12'h07F, 8'h80, 1'b1, 64'h78008, 8'h80, 8'hFF};
        for (int c = 0; c < $size(cases); c++) begin
            run_case(c);
        end
        $display("errors: %0d check, %0d timeout", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/fetch_queue.sv
logic/exec_unit.sv
logic/core_top.sv
sim/tb_core.sv

//--- Makefile
TOP := tb_core
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > sim.log 2>&1; echo "exit status $$?" >> sim.log
	cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "exit status 0" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log
